//--- Bender.yml
package:
  name: cpu_core

sources:
  - design/mips_pkg.sv
  - design/pipe_reg.sv
  - design/fetch_unit.sv
  - design/reg_file.sv
  - design/decode_unit.sv
  - design/execute_unit.sv
  - design/hazard_unit.sv
  - design/cpu_core.sv
  - target: test
    files:
      - verification/cpu_core_tb.sv

//--- design/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::word_t     wb_dat_i,
    input  logic                wb_ack,
    output logic                wb_cyc,
    output logic                wb_stb,
    output mips_pkg::word_t     wb_adr,
    output logic                retire_valid,
    output mips_pkg::word_t     retire_pc,
    output logic                retire_reg_w,
    output mips_pkg::reg_addr_t retire_rd,
    output mips_pkg::word_t     retire_data
);

    mips_pkg::f_d_t     f_d_d;
    mips_pkg::f_d_t     f_d_q;
    mips_pkg::d_x_t     d_x_d;
    mips_pkg::d_x_t     d_x_q;
    mips_pkg::x_w_t     x_w_d;
    mips_pkg::x_w_t     x_w_q;
    mips_pkg::fwd_sel_e fwd_a;
    mips_pkg::fwd_sel_e fwd_b;
    mips_pkg::word_t    redirect_target;
    logic               redirect_valid;
    logic               mul_busy;
    logic               stall;
    logic               flush;

    ////////////////////
    // Fetch
    fetch_unit fetch0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .f_out          (f_d_d)
    );

    pipe_reg #(.payload_t(mips_pkg::f_d_t)) f_d_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .stall(stall),
        .flush(flush),
        .d    (f_d_d),
        .q    (f_d_q)
    );

    ////////////////////
    // Decode
    decode_unit decode0 (
        .clk   (clk),
        .rst_n (rst_n),
        .f_in  (f_d_q),
        .w_we  (x_w_q.reg_w),
        .w_addr(x_w_q.rd),
        .w_data(x_w_q.result),
        .d_out (d_x_d)
    );

    pipe_reg #(.payload_t(mips_pkg::d_x_t)) d_x_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .stall(stall),
        .flush(flush),
        .d    (d_x_d),
        .q    (d_x_q)
    );

    ////////////////////
    // Execute
    hazard_unit hazard0 (
        .x_rs          (d_x_q.rs),
        .x_rt          (d_x_q.rt),
        .w_rd          (x_w_q.rd),
        .w_reg_w       (x_w_q.reg_w),
        .mul_busy      (mul_busy),
        .redirect_valid(redirect_valid),
        .stall         (stall),
        .flush         (flush),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    execute_unit execute0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .x_in           (d_x_q),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .w_result       (x_w_q.result),
        .x_out          (x_w_d),
        .mul_busy       (mul_busy),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target)
    );

    // W takes bubbles while the multiplier holds X
    pipe_reg #(.payload_t(mips_pkg::x_w_t)) x_w_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .stall(1'b0),
        .flush(stall),
        .d    (x_w_d),
        .q    (x_w_q)
    );

    assign retire_valid = x_w_q.valid;
    assign retire_pc    = x_w_q.pc;
    assign retire_reg_w = x_w_q.reg_w;
    assign retire_rd    = x_w_q.rd;
    assign retire_data  = x_w_q.result;

endmodule

`default_nettype wire

//--- design/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::f_d_t      f_in,
    input  logic                w_we,
    input  mips_pkg::reg_addr_t w_addr,
    input  mips_pkg::word_t     w_data,
    output mips_pkg::d_x_t      d_out
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    logic [15:0]         imm16;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::word_t     rd_a;
    mips_pkg::word_t     rd_b;
    mips_pkg::d_x_t      dec;
    logic                known;

    assign opcode = f_in.instr[31:26];
    assign rs     = f_in.instr[25:21];
    assign rt     = f_in.instr[20:16];
    assign rd     = f_in.instr[15:11];
    assign funct  = f_in.instr[5:0];
    assign imm16  = f_in.instr[15:0];

    reg_file rf0 (
        .clk  (clk),
        .rst_n(rst_n),
        .ra   (rs),
        .rb   (rt),
        .we   (w_we),
        .wa   (w_addr),
        .wd   (w_data),
        .rd_a (rd_a),
        .rd_b (rd_b)
    );

    always_comb begin
        dec        = '0;
        known      = 1'b1;
        dec.valid  = 1'b1;
        dec.pc     = f_in.pc;
        dec.op_a   = rd_a;
        dec.op_b   = rd_b;
        dec.imm    = {{16{imm16[15]}}, imm16};
        dec.shamt  = f_in.instr[10:6];
        dec.rs     = rs;
        dec.rt     = rt;
        dec.rd     = rt;
        dec.target = {f_in.pc[31:28], f_in.instr[25:0], 2'b00};

        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dec.rd    = rd;
                dec.reg_w = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL:  dec.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  dec.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_JR: begin
                        dec.alu_op = mips_pkg::ALU_PASS_B;
                        dec.jr     = 1'b1;
                        dec.reg_w  = 1'b0;
                    end
                    // Moves pass rs through an OR with zero
                    mips_pkg::FN_MOVZ, mips_pkg::FN_MOVN: begin
                        dec.alu_op = mips_pkg::ALU_OR;
                        dec.b_sel  = 1'b1;
                        dec.imm    = '0;
                        dec.movz   = (funct == mips_pkg::FN_MOVZ);
                        dec.movn   = (funct == mips_pkg::FN_MOVN);
                    end
                    default: known = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                dec.alu_op = mips_pkg::ALU_ADD;
                dec.b_sel  = 1'b1;
                dec.reg_w  = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                dec.alu_op = mips_pkg::ALU_OR;
                dec.b_sel  = 1'b1;
                dec.reg_w  = 1'b1;
                dec.imm    = {16'h0000, imm16};
            end
            mips_pkg::OP_LUI: begin
                dec.alu_op = mips_pkg::ALU_LUI;
                dec.b_sel  = 1'b1;
                dec.reg_w  = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                dec.alu_op    = mips_pkg::ALU_PASS_B;
                dec.branch    = 1'b1;
                dec.branch_ne = (opcode == mips_pkg::OP_BNE);
            end
            mips_pkg::OP_J: begin
                dec.alu_op = mips_pkg::ALU_PASS_B;
                dec.jmp    = 1'b1;
            end
            mips_pkg::OP_MUL: begin
                dec.alu_op = mips_pkg::ALU_MUL;
                dec.rd     = rd;
                dec.reg_w  = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // Empty slot or unknown instruction becomes a bubble
    assign d_out = (f_in.valid && known) ? dec : '0;

endmodule

`default_nettype wire

//--- design/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::d_x_t     x_in,
    input  mips_pkg::fwd_sel_e fwd_a,
    input  mips_pkg::fwd_sel_e fwd_b,
    input  mips_pkg::word_t    w_result,
    output mips_pkg::x_w_t     x_out,
    output logic               mul_busy,
    output logic               redirect_valid,
    output mips_pkg::word_t    redirect_target
);

    mips_pkg::word_t                src_a;
    mips_pkg::word_t                src_b;
    mips_pkg::word_t                alu_b;
    mips_pkg::word_t                alu_res;
    mips_pkg::word_t                mul_a;
    mips_pkg::word_t                mul_b;
    mips_pkg::word_t                mul_a_q;
    mips_pkg::word_t                mul_b_q;
    mips_pkg::word_t                mul_acc;
    mips_pkg::word_t                mul_next;
    logic [3:0]                     mul_nib;
    logic [mips_pkg::MUL_CNT_W-1:0] mul_cnt;
    logic                           is_mul;
    logic                           taken;
    logic                           move_ok;

    assign src_a = (fwd_a == mips_pkg::FWD_FROM_W) ? w_result : x_in.op_a;
    assign src_b = (fwd_b == mips_pkg::FWD_FROM_W) ? w_result : x_in.op_b;
    assign alu_b = x_in.b_sel ? x_in.imm : src_b;

    ////////////////////
    // Multiplier, one nibble of B per cycle
    assign is_mul   = x_in.valid && (x_in.alu_op == mips_pkg::ALU_MUL);
    assign mul_busy = is_mul && (mul_cnt != mips_pkg::MUL_CNT_W'(mips_pkg::MUL_STEPS));

    // Step 0 takes live operands, forwarding is gone after that
    assign mul_a    = (mul_cnt == '0) ? src_a : mul_a_q;
    assign mul_b    = (mul_cnt == '0) ? src_b : mul_b_q;
    assign mul_nib  = 4'(mul_b >> {mul_cnt, 2'b00});
    assign mul_next = ((mul_cnt == '0) ? '0 : mul_acc)
                    + ((mul_a * mips_pkg::word_t'(mul_nib)) << {mul_cnt, 2'b00});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_cnt <= '0;
        end else if (mul_busy) begin
            mul_cnt <= mul_cnt + 1'b1;
        end else begin
            mul_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_busy) begin
            mul_acc <= mul_next;
            if (mul_cnt == '0) begin
                mul_a_q <= src_a;
                mul_b_q <= src_b;
            end
        end
    end

    ////////////////////
    // ALU and shifter
    always_comb begin
        case (x_in.alu_op)
            mips_pkg::ALU_ADD:    alu_res = src_a + alu_b;
            mips_pkg::ALU_SUB:    alu_res = src_a - alu_b;
            mips_pkg::ALU_AND:    alu_res = src_a & alu_b;
            mips_pkg::ALU_OR:     alu_res = src_a | alu_b;
            mips_pkg::ALU_XOR:    alu_res = src_a ^ alu_b;
            mips_pkg::ALU_SLT:    alu_res = {31'd0, $signed(src_a) < $signed(alu_b)};
            mips_pkg::ALU_SLL:    alu_res = src_b << x_in.shamt;
            mips_pkg::ALU_SRL:    alu_res = src_b >> x_in.shamt;
            mips_pkg::ALU_LUI:    alu_res = {alu_b[15:0], 16'h0000};
            mips_pkg::ALU_MUL:    alu_res = mul_acc;
            mips_pkg::ALU_PASS_B: alu_res = alu_b;
            default:              alu_res = '0;
        endcase
    end

    // Failed move test still retires, just without the write
    assign move_ok = x_in.movz ? (src_b == '0) :
                     x_in.movn ? (src_b != '0) : 1'b1;

    always_comb begin
        x_out.valid  = x_in.valid;
        x_out.pc     = x_in.pc;
        x_out.rd     = x_in.rd;
        x_out.reg_w  = x_in.reg_w && move_ok;
        x_out.result = alu_res;
    end

    ////////////////////
    // Branch and jump resolution
    assign taken          = x_in.branch && ((src_a == src_b) != x_in.branch_ne);
    assign redirect_valid = x_in.valid && (x_in.jmp || x_in.jr || taken);

    always_comb begin
        if (x_in.jr) begin
            redirect_target = src_a;
        end else if (x_in.jmp) begin
            redirect_target = x_in.target;
        end else begin
            redirect_target = x_in.pc + 32'd4 + (x_in.imm << 2);
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            redirect_valid,
    input  mips_pkg::word_t redirect_target,
    input  mips_pkg::word_t wb_dat_i,
    input  logic            wb_ack,
    output logic            wb_cyc,
    output logic            wb_stb,
    output mips_pkg::word_t wb_adr,
    output mips_pkg::f_d_t  f_out
);

    mips_pkg::word_t pc;
    mips_pkg::word_t adr_q;
    mips_pkg::word_t hold_pc;
    mips_pkg::word_t hold_instr;
    logic            cyc_q;
    logic            drop;
    logic            hold_valid;
    logic            ack_ok;
    logic            start;

    assign ack_ok = cyc_q && wb_ack && !drop;
    // New transfer only after a one cycle gap and with no word parked
    assign start  = !cyc_q && !hold_valid && !stall && !redirect_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= mips_pkg::RESET_PC;
            cyc_q      <= 1'b0;
            drop       <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (start) begin
                cyc_q <= 1'b1;
                pc    <= pc + 32'd4;
            end else if (cyc_q && wb_ack) begin
                cyc_q <= 1'b0;
            end

            // Redirect kills whatever is still on the bus
            if (redirect_valid) begin
                pc   <= redirect_target;
                drop <= cyc_q && !wb_ack;
            end else if (cyc_q && wb_ack) begin
                drop <= 1'b0;
            end

            if (redirect_valid) begin
                hold_valid <= 1'b0;
            end else if (ack_ok && stall) begin
                hold_valid <= 1'b1;
            end else if (!stall) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= pc;
        end
        if (ack_ok && stall) begin
            hold_pc    <= adr_q;
            hold_instr <= wb_dat_i;
        end
    end

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_adr = adr_q;

    // Parked word goes first, otherwise the bus data passes straight on
    always_comb begin
        f_out.valid = hold_valid || ack_ok;
        f_out.pc    = hold_valid ? hold_pc : adr_q;
        f_out.instr = hold_valid ? hold_instr : wb_dat_i;
    end

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  mips_pkg::reg_addr_t x_rs,
    input  mips_pkg::reg_addr_t x_rt,
    input  mips_pkg::reg_addr_t w_rd,
    input  logic                w_reg_w,
    input  logic                mul_busy,
    input  logic                redirect_valid,
    output logic                stall,
    output logic                flush,
    output mips_pkg::fwd_sel_e  fwd_a,
    output mips_pkg::fwd_sel_e  fwd_b
);

    // W result bypasses the stale operand read in decode
    assign fwd_a = (w_reg_w && (w_rd != '0) && (w_rd == x_rs)) ?
                   mips_pkg::FWD_FROM_W : mips_pkg::FWD_NONE;
    assign fwd_b = (w_reg_w && (w_rd != '0) && (w_rd == x_rt)) ?
                   mips_pkg::FWD_FROM_W : mips_pkg::FWD_NONE;

    assign stall = mul_busy;
    assign flush = redirect_valid;

endmodule

`default_nettype wire

//--- design/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam int    MUL_STEPS = 8;
    localparam int    MUL_CNT_W = $clog2(MUL_STEPS + 1);

    ////////////////////
    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_MUL   = 6'h1c;

    // R-type function field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_MOVZ = 6'h0a;
    localparam logic [5:0] FN_MOVN = 6'h0b;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLL, ALU_SRL, ALU_LUI, ALU_MUL, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_W
    } fwd_sel_e;

    ////////////////////
    // Stage payloads, all zeros is a bubble
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } f_d_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     imm;
        logic      b_sel;
        logic [4:0] shamt;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic      reg_w;
        logic      branch;
        logic      branch_ne;
        logic      jmp;
        logic      jr;
        logic      movz;
        logic      movn;
        word_t     target;
    } d_x_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_w;
        word_t     result;
    } x_w_t;

endpackage

`default_nettype wire

//--- design/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Stall wins over flush, so a held instruction is never lost
    always_ff @(posedge clk) begin
        if (!rst_n || (flush && !stall)) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t ra,
    input  mips_pkg::reg_addr_t rb,
    input  logic                we,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::word_t     wd,
    output mips_pkg::word_t     rd_a,
    output mips_pkg::word_t     rd_b
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is bypassed to the readers
    assign rd_a = (ra == '0) ? '0 : ((we && wa == ra) ? wd : regs[ra]);
    assign rd_b = (rb == '0) ? '0 : ((we && wa == rb) ? wd : regs[rb]);

endmodule

`default_nettype wire

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

    typedef struct packed {
        logic [3:0]  test_id;
        logic [31:0] instr;
        logic        retires;
        logic        reg_w;
        logic [4:0]  rd;
        logic [31:0] data;
    } entry_t;

    logic                clk;
    logic                rst_n;
    mips_pkg::word_t     wb_dat_i;
    logic                wb_ack;
    logic                wb_cyc;
    logic                wb_stb;
    mips_pkg::word_t     wb_adr;
    logic                retire_valid;
    mips_pkg::word_t     retire_pc;
    logic                retire_reg_w;
    mips_pkg::reg_addr_t retire_rd;
    mips_pkg::word_t     retire_data;

    entry_t          prog_table [$];
    logic [31:0]     imem [0:63];
    int              n_prog;
    int unsigned     lcg_state;
    int              ack_wait;
    logic            xfer_busy;
    mips_pkg::word_t xfer_adr;
    int              total_checks;
    int              total_errors;
    int              test_checks;
    int              test_errors;
    int              tests_done;

    cpu_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_reg_w(retire_reg_w),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Instruction encoding
    function automatic logic [31:0] r_type_word(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] sh, input logic [5:0] fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type_word(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Past the end of the program the bus returns sll r0, r0, 0
    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        if ((adr >> 2) < n_prog) begin
            return imem[adr[7:2]];
        end
        return 32'h0000_0000;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "reset state";
            1:       return "immediates and ALU";
            2:       return "forwarding";
            3:       return "shifts and compare";
            4:       return "multiplier stall";
            5:       return "control flow";
            default: return "conditional moves";
        endcase
    endfunction

    task automatic push_entry(input int test, input logic [31:0] instr, input logic retires,
                              input logic reg_w, input logic [4:0] rd, input logic [31:0] data);
        entry_t e;
        e.test_id = test;
        e.instr   = instr;
        e.retires = retires;
        e.reg_w   = reg_w;
        e.rd      = rd;
        e.data    = data;
        prog_table.push_back(e);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        total_checks++;
        test_checks++;
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d (%s): %0d checks, %0d errors", id, test_name(id),
                 test_checks, test_errors);
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // 200 cycles cover a MUL plus the slowest fetch
    task automatic wait_retire(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 200) begin
            @(negedge clk);
            seen = retire_valid;
            cycles++;
        end
    endtask

    ////////////////////
    // Program in address order with one expected retire record per word
    task automatic build_program();
        push_entry(1, i_type_word(mips_pkg::OP_ADDIU, 0, 1, 16'h0005), 1, 1, 1, 32'd5);
        push_entry(1, i_type_word(mips_pkg::OP_ADDIU, 0, 2, 16'h0007), 1, 1, 2, 32'd7);
        push_entry(1, i_type_word(mips_pkg::OP_ORI, 0, 4, 16'h8f0f), 1, 1, 4, 32'h0000_8f0f);
        push_entry(1, i_type_word(mips_pkg::OP_LUI, 0, 8, 16'h1234), 1, 1, 8, 32'h1234_0000);
        push_entry(1, r_type_word(mips_pkg::OP_RTYPE, 1, 2, 10, 0, mips_pkg::FN_SUBU),
                   1, 1, 10, 32'hffff_fffe);
        // r0 write still retires while the next read sees zero
        push_entry(1, i_type_word(mips_pkg::OP_ADDIU, 0, 0, 16'h0009), 1, 1, 0, 32'd9);
        push_entry(1, r_type_word(mips_pkg::OP_RTYPE, 0, 1, 11, 0, mips_pkg::FN_ADDU),
                   1, 1, 11, 32'd5);

        push_entry(2, r_type_word(mips_pkg::OP_RTYPE, 1, 2, 3, 0, mips_pkg::FN_ADDU),
                   1, 1, 3, 32'd12);
        push_entry(2, r_type_word(mips_pkg::OP_RTYPE, 3, 1, 12, 0, mips_pkg::FN_ADDU),
                   1, 1, 12, 32'd17);
        push_entry(2, r_type_word(mips_pkg::OP_RTYPE, 3, 2, 13, 0, mips_pkg::FN_SUBU),
                   1, 1, 13, 32'd5);

        push_entry(3, r_type_word(mips_pkg::OP_RTYPE, 0, 2, 5, 2, mips_pkg::FN_SLL),
                   1, 1, 5, 32'd28);
        push_entry(3, r_type_word(mips_pkg::OP_RTYPE, 0, 8, 14, 8, mips_pkg::FN_SRL),
                   1, 1, 14, 32'h0012_3400);
        push_entry(3, r_type_word(mips_pkg::OP_RTYPE, 10, 1, 15, 0, mips_pkg::FN_SLT),
                   1, 1, 15, 32'd1);

        push_entry(4, r_type_word(mips_pkg::OP_MUL, 1, 2, 6, 0, 6'h02), 1, 1, 6, 32'd35);
        push_entry(4, r_type_word(mips_pkg::OP_RTYPE, 6, 1, 7, 0, mips_pkg::FN_ADDU),
                   1, 1, 7, 32'd40);

        // Taken beq skips one word while j and jr skip further
        push_entry(5, i_type_word(mips_pkg::OP_BEQ, 1, 1, 16'h0001), 1, 0, 0, 32'd0);
        push_entry(5, i_type_word(mips_pkg::OP_ADDIU, 0, 16, 16'h0099), 0, 0, 0, 32'd0);
        push_entry(5, i_type_word(mips_pkg::OP_BNE, 1, 1, 16'h0005), 1, 0, 0, 32'd0);
        push_entry(5, j_type_word(mips_pkg::OP_J, 26'd20), 1, 0, 0, 32'd0);
        push_entry(5, i_type_word(mips_pkg::OP_ADDIU, 0, 16, 16'h0098), 0, 0, 0, 32'd0);
        push_entry(5, i_type_word(mips_pkg::OP_ADDIU, 0, 17, 16'h0060), 1, 1, 17, 32'h60);
        push_entry(5, r_type_word(mips_pkg::OP_RTYPE, 17, 0, 0, 0, mips_pkg::FN_JR),
                   1, 0, 0, 32'd0);
        push_entry(5, i_type_word(mips_pkg::OP_ADDIU, 0, 16, 16'h0097), 0, 0, 0, 32'd0);
        push_entry(5, i_type_word(mips_pkg::OP_ADDIU, 0, 16, 16'h0096), 0, 0, 0, 32'd0);

        push_entry(6, r_type_word(mips_pkg::OP_RTYPE, 2, 0, 9, 0, mips_pkg::FN_MOVZ),
                   1, 1, 9, 32'd7);
        push_entry(6, r_type_word(mips_pkg::OP_RTYPE, 2, 0, 18, 0, mips_pkg::FN_MOVN),
                   1, 0, 0, 32'd0);
        // r18 must still hold its reset value
        push_entry(6, r_type_word(mips_pkg::OP_RTYPE, 9, 18, 19, 0, mips_pkg::FN_ADDU),
                   1, 1, 19, 32'd7);
    endtask

    ////////////////////
    // Wishbone slave with 0 to 3 idle cycles before each ack
    always @(posedge clk) begin : wb_slave
        int delay;
        if (!rst_n || wb_ack) begin
            wb_ack    <= 1'b0;
            xfer_busy <= 1'b0;
        end else if (xfer_busy || (wb_cyc && wb_stb)) begin
            if (xfer_busy) begin
                // Request stays up with a steady address until the ack
                compare_value("wb_cyc", wb_cyc, 32'd1);
                compare_value("wb_stb", wb_stb, 32'd1);
                compare_value("wb_adr", wb_adr, xfer_adr);
                delay = ack_wait;
            end else begin
                delay = lcg_next() % 4;
                xfer_adr <= wb_adr;
            end
            xfer_busy <= 1'b1;
            if (delay == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= fetch_word(wb_adr);
            end else begin
                ack_wait <= delay - 1;
            end
        end
    end

    initial begin : main
        int     i;
        bit     seen;
        bit     abort;
        entry_t e;
        rst_n        = 1'b0;
        wb_ack       = 1'b0;
        wb_dat_i     = '0;
        xfer_busy    = 1'b0;
        xfer_adr     = '0;
        ack_wait     = 0;
        lcg_state    = 15;
        total_checks = 0;
        total_errors = 0;
        test_checks  = 0;
        test_errors  = 0;
        tests_done   = 0;
        abort        = 1'b0;

        build_program();
        n_prog = prog_table.size();
        for (i = 0; i < n_prog; i++) begin
            imem[i] = prog_table[i].instr;
        end

        // Bus and retire port idle while in reset
        repeat (7) @(posedge clk);
        @(negedge clk);
        compare_value("wb_cyc", wb_cyc, 32'd0);
        compare_value("wb_stb", wb_stb, 32'd0);
        compare_value("retire_valid", retire_valid, 32'd0);
        report_test(0);
        @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < n_prog && !abort; i++) begin
            e = prog_table[i];
            if (e.retires) begin
                wait_retire(seen);
                if (!seen) begin
                    $display("Timeout: instruction %0d at pc 0x%08h never retired", i, i * 4);
                    total_errors++;
                    test_errors++;
                    abort = 1'b1;
                end else begin
                    compare_value("retire_pc", retire_pc, i * 4);
                    compare_value("retire_reg_w", retire_reg_w, e.reg_w);
                    if (e.reg_w) begin
                        compare_value("retire_rd", retire_rd, e.rd);
                        compare_value("retire_data", retire_data, e.data);
                    end
                end
            end
            if (abort || i == n_prog - 1 || prog_table[i + 1].test_id != e.test_id) begin
                report_test(e.test_id);
            end
        end

        $display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/mips_pkg.sv
design/pipe_reg.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/hazard_unit.sv
design/cpu_core.sv
verification/cpu_core_tb.sv
